/* Bender.yml */
package:
  name: phold

sources:
  - files:
      - hdl/phold_pkg.sv
      - hdl/rr_arbiter.sv
      - hdl/event_queue.sv
      - hdl/phold_core.sv
      - hdl/gvt_unit.sv
      - hdl/event_scheduler.sv
      - hdl/phold_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/phold_tb.sv

/* bench/phold_checks.svh */
`ifndef PHOLD_CHECKS_SVH
`define PHOLD_CHECKS_SVH

// first error ends the simulation
task automatic stop_on_error();
   $display("TB FAILED");
   $fatal(1, "stopped at first error");
endtask

// failures that are not a wrong value
task automatic report_problem(input string what);
   $display("%0t: %s", $time, what);
   stop_on_error();
endtask

task automatic check_time(input string name, input time_t expected, input time_t actual);
   if (actual !== expected) begin
      $display("Fail %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_on_error();
   end
endtask

task automatic check_lp(input string name, input lp_id_t expected, input lp_id_t actual);
   if (actual !== expected) begin
      $display("Fail %0t: %s expected %0d, got %0d", $time, name, expected, actual);
      stop_on_error();
   end
endtask

// single bit results and derived conditions
task automatic check_bit(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      $display("Fail %0t: %s expected %b, got %b", $time, name, expected, actual);
      stop_on_error();
   end
endtask

`endif

/* bench/phold_tb.sv */
`timescale 1ns/1ps

module phold_tb
   import phold_pkg::*;
();

   localparam int    MAX_TESTS = 64;
   localparam string TEST_FILE = "bench/phold_tests.txt";

   logic   clk;
   logic   rst_n;
   time_t  sim_end;
   time_t  gvt;
   logic   rtn_vld;
   logic   sent_vld;
   lp_id_t sent_lp;
   time_t  sent_time;

   // one sim_end per run
   time_t  tests [MAX_TESTS];
   int     num_tests;
   int     run_idx;
   longint limit_cycles;
   logic   limit_ready;

   `include "phold_checks.svh"

   phold_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .sim_end   (sim_end),
      .gvt       (gvt),
      .rtn_vld   (rtn_vld),
      .sent_vld  (sent_vld),
      .sent_lp   (sent_lp),
      .sent_time (sent_time)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // entries left unknown mark the end of the file
   task automatic load_tests();
      foreach (tests[i])
         tests[i] = 'x;
      $readmemh(TEST_FILE, tests);
      num_tests = 0;
      while (num_tests < MAX_TESTS && !$isunknown(tests[num_tests]))
         num_tests++;
      limit_cycles = 1000;
      for (int i = 0; i < num_tests; i++)
         limit_cycles += (longint'(tests[i]) + 2) * NUM_LP * 16;
   endtask

   task automatic check_quiet_outputs();
      check_bit("rtn_vld", 1'b0, rtn_vld);
      check_bit("sent_vld", 1'b0, sent_vld);
      check_time("gvt", '0, gvt);
   endtask

   initial begin
      wait (limit_ready === 1'b1);
      repeat (limit_cycles) @(posedge clk);
      report_problem($sformatf("watchdog expired after %0d cycles, run %0d of %0d never returned",
                               limit_cycles, run_idx + 1, num_tests));
   end

   // run sequencing
   initial begin
      rst_n       = 1'b0;
      sim_end     = '0;
      run_idx     = 0;
      limit_ready = 1'b0;
      load_tests();
      if (num_tests == 0)
         report_problem($sformatf("no sim_end values found in %s", TEST_FILE));
      limit_ready = 1'b1;
      sim_end     = tests[0];
      repeat (5) begin
         @(negedge clk);
         check_quiet_outputs();
      end
      rst_n = 1'b1;
      @(negedge clk);
      check_quiet_outputs();
      for (run_idx = 0; run_idx < num_tests; run_idx++) begin
         while (rtn_vld !== 1'b1)
            @(negedge clk);
         check_bit("gvt > sim_end", 1'b1, gvt > sim_end);
         @(negedge clk);
         // return strobe lasts one cycle
         check_bit("rtn_vld", 1'b0, rtn_vld);
         if (run_idx + 1 < num_tests)
            sim_end = tests[run_idx + 1];
      end
      $display("TB PASSED");
      $finish;
   end

   // dispatch and gvt monitor
   initial begin : monitor
      int                sent_count;
      logic              in_gap;
      time_t             last_gvt;
      sent_count = 0;
      in_gap     = 1'b1;
      last_gvt   = '0;
      wait (rst_n === 1'b1);
      forever begin
         @(negedge clk);
         if (!in_gap)
            check_bit("gvt >= previous gvt", 1'b1, gvt >= last_gvt);
         if (sent_vld === 1'b1) begin
            // first strobe of a run
            if (in_gap) begin
               check_time("gvt", '0, gvt);
               in_gap     = 1'b0;
               sent_count = 0;
            end
            check_bit("sent_lp < NUM_LP", 1'b1, sent_lp < NUM_LP);
            check_bit("sent_time >= gvt", 1'b1, sent_time >= gvt);
            // seeds leave in slot order, which is lp order
            if (sent_count < NUM_LP) begin
               check_time("sent_time", '0, sent_time);
               check_lp("sent_lp", lp_id_t'(sent_count), sent_lp);
            end
            sent_count++;
         end
         last_gvt = gvt;
         if (rtn_vld === 1'b1)
            in_gap = 1'b1;
      end
   end

endmodule

/* bench/phold_tests.txt */
// one run per line: sim_end in hex
// a run returns once gvt passes this value
0000
0004
0010
0001
0025
0060
0008
00a0

/* hdl/event_queue.sv */
`timescale 1ns/1ps

module event_queue
   import phold_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   clear,
   input  logic   enq,
   input  logic   deq,
   input  lp_id_t enq_lp,
   input  time_t  enq_time,
   output lp_id_t head_lp,
   output time_t  head_time,
   output logic   full,
   output logic   empty
);

   lp_id_t               lp_mem   [NUM_LP];
   time_t                time_mem [NUM_LP];
   logic [NUM_LP-1:0]    slot_vld;
   logic [NB_QCNT-1:0]   count;
   logic [NB_LPID-1:0]   free_idx;
   logic [NB_LPID-1:0]   head_idx;
   logic                 do_enq;
   logic                 do_deq;

   assign full   = (count == NB_QCNT'(NUM_LP));
   assign empty  = (count == '0);
   assign do_enq = enq && !full;
   assign do_deq = deq && !empty;

   // lowest free slot
   always_comb begin
      free_idx = '0;
      for (int i = NUM_LP - 1; i >= 0; i--) begin
         if (!slot_vld[i])
            free_idx = NB_LPID'(i);
      end
   end

   // minimum search, strict compare keeps the lowest slot on a tie
   always_comb begin
      time_t best;
      logic  found;
      best     = '1;
      found    = 1'b0;
      head_idx = '0;
      for (int i = 0; i < NUM_LP; i++) begin
         if (slot_vld[i] && (!found || time_mem[i] < best)) begin
            found    = 1'b1;
            best     = time_mem[i];
            head_idx = NB_LPID'(i);
         end
      end
   end

   assign head_lp   = lp_mem[head_idx];
   assign head_time = time_mem[head_idx];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         slot_vld <= '0;
         count    <= '0;
      end else if (clear) begin
         slot_vld <= '0;
         count    <= '0;
      end else begin
         if (do_enq)
            slot_vld[free_idx] <= 1'b1;
         if (do_deq)
            slot_vld[head_idx] <= 1'b0;
         count <= count + NB_QCNT'(do_enq) - NB_QCNT'(do_deq);
      end
   end

   // entry payload
   always_ff @(posedge clk) begin
      if (do_enq) begin
         lp_mem[free_idx]   <= enq_lp;
         time_mem[free_idx] <= enq_time;
      end
   end

endmodule

/* hdl/event_scheduler.sv */
`timescale 1ns/1ps

module event_scheduler
   import phold_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  time_t               sim_end,
   input  time_t               gvt,
   input  logic                q_full,
   input  logic                q_empty,
   input  lp_id_t              head_lp,
   input  time_t               head_time,
   input  logic                rcv_eval,
   input  core_id_t            rcv_egnt,
   input  logic                send_eval,
   input  logic [NUM_CORE-1:0] send_vgnt,
   input  lp_id_t              new_lp [NUM_CORE],
   input  time_t               new_time [NUM_CORE],
   output logic                enq,
   output logic                deq,
   output lp_id_t              enq_lp,
   output time_t               enq_time,
   output logic [NUM_CORE-1:0] ack,
   output logic [NUM_CORE-1:0] event_valid,
   output logic                running,
   output logic                init_clear,
   output logic                rtn_vld,
   output logic                sent_vld,
   output lp_id_t              sent_lp,
   output time_t               sent_time
);

   run_state_t         state;
   run_state_t         state_nxt;
   logic [NB_QCNT-1:0] init_cnt;
   logic               init_done;
   logic               queue_busy;

   assign running    = (state == RUNNING);
   assign init_clear = (state == IDLE);
   assign rtn_vld    = (state == FINISHED);
   assign init_done  = (init_cnt == NB_QCNT'(NUM_LP));

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE:     state_nxt = INIT;
         INIT:     if (init_done) state_nxt = READY;
         READY:    state_nxt = RUNNING;
         RUNNING:  if (gvt > sim_end) state_nxt = FINISHED;
         FINISHED: state_nxt = IDLE;
         default:  state_nxt = IDLE;
      endcase
   end

   // one queue operation, then a blocked cycle; enqueue wins
   always_comb begin
      enq = 1'b0;
      deq = 1'b0;
      if (!queue_busy) begin
         if (state == INIT) begin
            enq = !init_done;
         end else if (running) begin
            enq = rcv_eval && !q_full;
            deq = !enq && !q_empty && send_eval;
         end
      end
      ack = '0;
      if (running && enq)
         ack[rcv_egnt] = 1'b1;
   end

   // seed events are lp k at time 0
   assign enq_lp      = (state == INIT) ? init_cnt[NB_LPID-1:0] : new_lp[rcv_egnt];
   assign enq_time    = (state == INIT) ? '0 : new_time[rcv_egnt];
   assign event_valid = send_vgnt & {NUM_CORE{deq}};

   assign sent_vld  = deq;
   assign sent_lp   = head_lp;
   assign sent_time = head_time;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         init_cnt   <= '0;
         queue_busy <= 1'b0;
      end else begin
         state      <= state_nxt;
         queue_busy <= enq | deq;
         if (state != INIT)
            init_cnt <= '0;
         else if (enq)
            init_cnt <= init_cnt + NB_QCNT'(1);
      end
   end

endmodule

/* hdl/gvt_unit.sv */
`timescale 1ns/1ps

module gvt_unit
   import phold_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                running,
   input  logic                clear,
   input  logic                q_empty,
   input  time_t               head_time,
   input  logic [NUM_CORE-1:0] core_busy,
   input  time_t               core_lvt [NUM_CORE],
   output time_t               gvt
);

   time_t min_time;
   logic  min_vld;

   // oldest pending event over queue head and busy cores
   always_comb begin
      min_vld  = !q_empty;
      min_time = q_empty ? '1 : head_time;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_busy[i] && (!min_vld || core_lvt[i] < min_time)) begin
            min_vld  = 1'b1;
            min_time = core_lvt[i];
         end
      end
   end

   // only ever moves forward, holds with nothing pending
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (clear) begin
         gvt <= '0;
      end else if (running && min_vld && min_time > gvt) begin
         gvt <= min_time;
      end
   end

endmodule

/* hdl/phold_core.sv */
`timescale 1ns/1ps

module phold_core
   import phold_pkg::*;
#(
   parameter int CORE_IDX = 0
)(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   event_valid,
   input  lp_id_t cur_lp,
   input  time_t  cur_time,
   input  logic   ack,
   input  logic   flush,
   output logic   ready,
   output logic   busy,
   output time_t  lvt,
   output logic   new_event_ready,
   output lp_id_t new_lp,
   output time_t  new_time
);

   typedef enum logic [1:0] {CORE_IDLE, CORE_PROC, CORE_HOLD} core_state_t;
   typedef logic [$clog2(PROC_CYCLES)-1:0] proc_cnt_t;

   core_state_t         state;
   proc_cnt_t           proc_cnt;
   logic [LFSR_WID-1:0] lfsr;
   lp_id_t              lp_q;
   logic                proc_done;

   // last processing cycle, child becomes visible on the next one
   assign proc_done = (state == CORE_PROC) && (proc_cnt == proc_cnt_t'(PROC_CYCLES - 2));

   assign ready           = (state == CORE_IDLE);
   assign busy            = (state != CORE_IDLE);
   assign new_event_ready = (state == CORE_HOLD);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= CORE_IDLE;
         proc_cnt <= '0;
         lfsr     <= LFSR_SEED_BASE + LFSR_WID'(CORE_IDX);
      end else if (flush) begin
         state    <= CORE_IDLE;
         proc_cnt <= '0;
      end else begin
         case (state)
            CORE_IDLE:
               if (event_valid) begin
                  state    <= CORE_PROC;
                  proc_cnt <= '0;
               end
            CORE_PROC:
               if (proc_done) begin
                  state <= CORE_HOLD;
                  // x^24 + x^23 + x^22 + x^17 + 1
                  lfsr  <= {lfsr[LFSR_WID-2:0], lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16]};
               end else begin
                  proc_cnt <= proc_cnt + proc_cnt_t'(1);
               end
            CORE_HOLD:
               if (ack)
                  state <= CORE_IDLE;
            default:
               state <= CORE_IDLE;
         endcase
      end
   end

   // event and child payload
   always_ff @(posedge clk) begin
      if (state == CORE_IDLE && event_valid) begin
         lvt  <= cur_time;
         lp_q <= cur_lp;
      end
      if (proc_done) begin
         new_lp   <= lp_q ^ lfsr[NB_LPID-1:0];
         new_time <= lvt + time_t'(1) + time_t'(lfsr[NB_LPID +: NB_RAND_INC]);
      end
   end

endmodule

/* hdl/phold_pkg.sv */
package phold_pkg;

   // engine sizes
   localparam int NUM_CORE  = 4;
   localparam int NB_COREID = 2;
   localparam int NUM_LP    = 16;
   localparam int NB_LPID   = 4;
   localparam int TIME_WID  = 16;

   // queue depth equals NUM_LP, so the count needs one extra bit
   localparam int NB_QCNT = 5;

   // core behaviour
   localparam int PROC_CYCLES = 4;
   localparam int NB_RAND_INC = 3;
   localparam int LFSR_WID    = 24;

   // each core adds its own index to this
   localparam logic [LFSR_WID-1:0] LFSR_SEED_BASE = 24'h3a91c5;

   // event fields
   typedef logic [TIME_WID-1:0]  time_t;
   typedef logic [NB_LPID-1:0]   lp_id_t;
   typedef logic [NB_COREID-1:0] core_id_t;

   // top level run sequence
   typedef enum logic [2:0] {
      IDLE,
      INIT,
      READY,
      RUNNING,
      FINISHED
   } run_state_t;

endpackage

/* hdl/phold_top.sv */
`timescale 1ns/1ps

module phold_top
   import phold_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  time_t  sim_end,
   output time_t  gvt,
   output logic   rtn_vld,
   output logic   sent_vld,
   output lp_id_t sent_lp,
   output time_t  sent_time
);

   logic                enq;
   logic                deq;
   lp_id_t              enq_lp;
   time_t               enq_time;
   lp_id_t              head_lp;
   time_t               head_time;
   logic                q_full;
   logic                q_empty;
   logic                running;
   logic                init_clear;

   // per core signals
   logic [NUM_CORE-1:0] rcv_req;
   logic [NUM_CORE-1:0] send_req;
   logic [NUM_CORE-1:0] send_vgnt;
   logic [NUM_CORE-1:0] ack;
   logic [NUM_CORE-1:0] event_valid;
   logic [NUM_CORE-1:0] core_busy;
   time_t               core_lvt [NUM_CORE];
   lp_id_t              core_new_lp [NUM_CORE];
   time_t               core_new_time [NUM_CORE];
   logic                rcv_eval;
   core_id_t            rcv_egnt;
   logic                send_eval;

   event_scheduler u_sched (
      .clk (clk), .rst_n (rst_n), .sim_end (sim_end), .gvt (gvt),
      .q_full (q_full), .q_empty (q_empty), .head_lp (head_lp), .head_time (head_time),
      .rcv_eval (rcv_eval), .rcv_egnt (rcv_egnt), .send_eval (send_eval),
      .send_vgnt (send_vgnt), .new_lp (core_new_lp), .new_time (core_new_time),
      .enq (enq), .deq (deq), .enq_lp (enq_lp), .enq_time (enq_time),
      .ack (ack), .event_valid (event_valid), .running (running),
      .init_clear (init_clear), .rtn_vld (rtn_vld), .sent_vld (sent_vld),
      .sent_lp (sent_lp), .sent_time (sent_time)
   );

   event_queue u_queue (
      .clk (clk), .rst_n (rst_n), .clear (init_clear), .enq (enq), .deq (deq),
      .enq_lp (enq_lp), .enq_time (enq_time), .head_lp (head_lp),
      .head_time (head_time), .full (q_full), .empty (q_empty)
   );

   // children coming back from the cores
   rr_arbiter u_rcv_arb (
      .clk (clk), .rst_n (rst_n), .req (rcv_req),
      .vgnt (), .eval (rcv_eval), .egnt (rcv_egnt)
   );

   // idle cores waiting for work
   rr_arbiter u_send_arb (
      .clk (clk), .rst_n (rst_n), .req (send_req),
      .vgnt (send_vgnt), .eval (send_eval), .egnt ()
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
      phold_core #(.CORE_IDX (g)) u_core (
         .clk (clk), .rst_n (rst_n), .event_valid (event_valid[g]),
         .cur_lp (head_lp), .cur_time (head_time), .ack (ack[g]), .flush (init_clear),
         .ready (send_req[g]), .busy (core_busy[g]), .lvt (core_lvt[g]),
         .new_event_ready (rcv_req[g]), .new_lp (core_new_lp[g]),
         .new_time (core_new_time[g])
      );
   end

   gvt_unit u_gvt (
      .clk (clk), .rst_n (rst_n), .running (running), .clear (init_clear),
      .q_empty (q_empty), .head_time (head_time), .core_busy (core_busy),
      .core_lvt (core_lvt), .gvt (gvt)
   );

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/1ps

module rr_arbiter
   import phold_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic [NUM_CORE-1:0] req,
   output logic [NUM_CORE-1:0] vgnt,
   output logic                eval,
   output core_id_t            egnt
);

   // requester with the highest priority this cycle
   core_id_t ptr;

   // first requester at or after the pointer
   always_comb begin
      core_id_t idx;
      logic     found;
      found = 1'b0;
      egnt  = ptr;
      vgnt  = '0;
      for (int i = 0; i < NUM_CORE; i++) begin
         idx = ptr + core_id_t'(i);
         if (!found && req[idx]) begin
            found = 1'b1;
            egnt  = idx;
         end
      end
      if (found)
         vgnt[egnt] = 1'b1;
      eval = found;
   end

   // move past the winner whenever anyone asked
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (eval) begin
         ptr <= egnt + core_id_t'(1);
      end
   end

endmodule

/* tb.f */
hdl/phold_pkg.sv
hdl/rr_arbiter.sv
hdl/event_queue.sv
hdl/phold_core.sv
hdl/gvt_unit.sv
hdl/event_scheduler.sv
hdl/phold_top.sv
+incdir+bench
bench/phold_tb.sv
